// File: Bender.yml
package:
  name: risc_v_top

sources:
  - common/rv_pkg.sv
  - rtl/core/rv_decode.sv
  - rtl/core/rv_regfile.sv
  - rtl/core/rv_alu.sv
  - rtl/core/rv_core.sv
  - rtl/rv_mem_map.sv
  - rtl/uart/uart_tx.sv
  - rtl/risc_v_top.sv
  - target: simulation
    files:
      - sim/risc_v_top_asserts.sv
      - sim/tb_risc_v_top.sv

// File: common/rv_pkg.sv
package rv_pkg;

	// Base opcodes of the supported subset
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	// ALU operations
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR  = 3'd3;
	localparam logic [2:0] ALU_XOR = 3'd4;
	localparam logic [2:0] ALU_SLT = 3'd5;

	// Writeback mux select, same order as the four-way mux in WB
	localparam logic [1:0] WB_ALU = 2'd0;
	localparam logic [1:0] WB_MEM = 2'd1;
	localparam logic [1:0] WB_PC4 = 2'd2;
	localparam logic [1:0] WB_IMM = 2'd3;

	// ADDI x0,x0,0
	localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

	// Memory map
	localparam int          RAM_ADDR_W   = 7;
	localparam logic [31:0] UART_TX_ADDR = 32'h8000_0000;

	// UART transmitter
	localparam int CLKS_PER_BIT  = 8;
	localparam int TX_FIFO_DEPTH = 8;
	localparam int TX_PTR_W      = $clog2(TX_FIFO_DEPTH);
	localparam int BAUD_CNT_W    = $clog2(CLKS_PER_BIT);

	// One instruction word seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} rv_instr_t;

endpackage

// File: rtl/core/rv_alu.sv
module rv_alu (
	input  logic [31:0] i_a,
	input  logic [31:0] i_b,
	input  logic [2:0]  i_alu_op,
	output logic [31:0] o_result,
	output logic        o_zero
);
	import rv_pkg::*;

	always_comb begin
		case (i_alu_op)
			ALU_ADD: o_result = i_a + i_b;
			ALU_SUB: o_result = i_a - i_b;
			ALU_AND: o_result = i_a & i_b;
			ALU_OR:  o_result = i_a | i_b;
			ALU_XOR: o_result = i_a ^ i_b;
			// Signed compare
			ALU_SLT: o_result = {31'h0, $signed(i_a) < $signed(i_b)};
			default: o_result = 32'h0;
		endcase
	end

	// Used by BEQ and BNE in MEM
	assign o_zero = (o_result == 32'h0);

endmodule

// File: rtl/core/rv_core.sv
module rv_core (
	input  logic        i_clk,
	input  logic        i_rst_n,
	output logic [31:0] o_imem_addr,
	input  logic [31:0] i_imem_data,
	output logic [31:0] o_dmem_addr,
	output logic [31:0] o_dmem_wdata,
	output logic        o_dmem_we,
	output logic        o_dmem_re,
	input  logic [31:0] i_dmem_rdata
);
	import rv_pkg::*;

	// Fetch
	logic [31:0] pc;
	logic [31:0] pc_next;
	logic        take_branch;

	// IF/ID
	rv_instr_t   ifid_instr;
	logic [31:0] ifid_pc;

	// Decode outputs
	logic [31:0] dec_imm;
	logic        dec_alu_src_a_pc, dec_alu_src_b_imm, dec_reg_write;
	logic        dec_mem_write, dec_mem_read, dec_branch, dec_bne, dec_jump;
	logic [2:0]  dec_alu_op;
	logic [1:0]  dec_wb_sel;
	logic [31:0] rs1_data, rs2_data;

	// ID/EX
	logic        idex_alu_src_a_pc, idex_alu_src_b_imm, idex_reg_write;
	logic        idex_mem_write, idex_mem_read, idex_branch, idex_bne, idex_jump;
	logic [2:0]  idex_alu_op;
	logic [1:0]  idex_wb_sel;
	logic [31:0] idex_pc, idex_rs1_data, idex_rs2_data, idex_imm;
	logic [4:0]  idex_rd;

	// Execute
	logic [31:0] alu_a, alu_b, alu_result, branch_target;
	logic        alu_zero;

	// EX/MEM
	logic        exmem_reg_write, exmem_mem_write, exmem_mem_read;
	logic        exmem_branch, exmem_bne, exmem_jump;
	logic [1:0]  exmem_wb_sel;
	logic [31:0] exmem_pc, exmem_target, exmem_alu_result, exmem_imm, exmem_rs2_data;
	logic        exmem_zero;
	logic [4:0]  exmem_rd;

	// MEM/WB
	logic        memwb_reg_write;
	logic [1:0]  memwb_wb_sel;
	logic [31:0] memwb_pc, memwb_mem_data, memwb_alu_result, memwb_imm;
	logic [4:0]  memwb_rd;
	logic [31:0] wb_data;

	assign o_imem_addr = pc;
	assign pc_next     = take_branch ? exmem_target : pc + 32'd4;

	rv_decode decode_i (
		.i_instr(ifid_instr),
		.o_imm(dec_imm),
		.o_alu_src_a_pc(dec_alu_src_a_pc),
		.o_alu_src_b_imm(dec_alu_src_b_imm),
		.o_reg_write(dec_reg_write),
		.o_mem_write(dec_mem_write),
		.o_mem_read(dec_mem_read),
		.o_branch(dec_branch),
		.o_bne(dec_bne),
		.o_jump(dec_jump),
		.o_alu_op(dec_alu_op),
		.o_wb_sel(dec_wb_sel)
	);

	// Read in ID, written back from MEM/WB
	rv_regfile regfile_i (
		.i_clk(i_clk),
		.i_we(memwb_reg_write),
		.i_waddr(memwb_rd),
		.i_wdata(wb_data),
		.i_raddr1(ifid_instr.r_fmt.rs1),
		.i_raddr2(ifid_instr.r_fmt.rs2),
		.o_rdata1(rs1_data),
		.o_rdata2(rs2_data)
	);

	// Operand muxes and target adder
	assign alu_a         = idex_alu_src_a_pc ? idex_pc : idex_rs1_data;
	assign alu_b         = idex_alu_src_b_imm ? idex_imm : idex_rs2_data;
	assign branch_target = idex_pc + idex_imm;

	rv_alu alu_i (
		.i_a(alu_a),
		.i_b(alu_b),
		.i_alu_op(idex_alu_op),
		.o_result(alu_result),
		.o_zero(alu_zero)
	);

	// Branch resolved in MEM
	assign take_branch = exmem_jump | (exmem_branch & (exmem_zero ^ exmem_bne));

	assign o_dmem_addr  = exmem_alu_result;
	assign o_dmem_wdata = exmem_rs2_data;
	assign o_dmem_we    = exmem_mem_write;
	assign o_dmem_re    = exmem_mem_read;

	// PC, instruction word and control fields
	// Taken branch squashes IF/ID, ID/EX and EX/MEM
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pc                 <= 32'h0;
			ifid_instr         <= NOP_INSTR;
			{idex_alu_src_a_pc, idex_alu_src_b_imm, idex_reg_write} <= '0;
			{idex_mem_write, idex_mem_read, idex_branch, idex_bne, idex_jump} <= '0;
			idex_alu_op        <= ALU_ADD;
			idex_wb_sel        <= WB_ALU;
			{exmem_reg_write, exmem_mem_write, exmem_mem_read} <= '0;
			{exmem_branch, exmem_bne, exmem_jump} <= '0;
			exmem_wb_sel       <= WB_ALU;
			memwb_reg_write    <= 1'b0;
			memwb_wb_sel       <= WB_ALU;
		end else begin
			pc                 <= pc_next;
			ifid_instr         <= take_branch ? NOP_INSTR : i_imem_data;
			idex_alu_src_a_pc  <= dec_alu_src_a_pc & ~take_branch;
			idex_alu_src_b_imm <= dec_alu_src_b_imm & ~take_branch;
			idex_reg_write     <= dec_reg_write & ~take_branch;
			idex_mem_write     <= dec_mem_write & ~take_branch;
			idex_mem_read      <= dec_mem_read & ~take_branch;
			idex_branch        <= dec_branch & ~take_branch;
			idex_bne           <= dec_bne & ~take_branch;
			idex_jump          <= dec_jump & ~take_branch;
			idex_alu_op        <= take_branch ? ALU_ADD : dec_alu_op;
			idex_wb_sel        <= take_branch ? WB_ALU : dec_wb_sel;
			exmem_reg_write    <= idex_reg_write & ~take_branch;
			exmem_mem_write    <= idex_mem_write & ~take_branch;
			exmem_mem_read     <= idex_mem_read & ~take_branch;
			exmem_branch       <= idex_branch & ~take_branch;
			exmem_bne          <= idex_bne & ~take_branch;
			exmem_jump         <= idex_jump & ~take_branch;
			exmem_wb_sel       <= take_branch ? WB_ALU : idex_wb_sel;
			// Branch itself still retires
			memwb_reg_write    <= exmem_reg_write;
			memwb_wb_sel       <= exmem_wb_sel;
		end
	end

	// Datapath fields qualified by the control bits above
	always_ff @(posedge i_clk) begin
		ifid_pc          <= pc;
		idex_pc          <= ifid_pc;
		idex_rs1_data    <= rs1_data;
		idex_rs2_data    <= rs2_data;
		idex_imm         <= dec_imm;
		idex_rd          <= ifid_instr.r_fmt.rd;
		exmem_pc         <= idex_pc;
		exmem_target     <= branch_target;
		exmem_alu_result <= alu_result;
		exmem_zero       <= alu_zero;
		exmem_imm        <= idex_imm;
		exmem_rs2_data   <= idex_rs2_data;
		exmem_rd         <= idex_rd;
		memwb_pc         <= exmem_pc;
		memwb_mem_data   <= i_dmem_rdata;
		memwb_alu_result <= exmem_alu_result;
		memwb_imm        <= exmem_imm;
		memwb_rd         <= exmem_rd;
	end

	// Link value is the JAL's own PC plus 4
	always_comb begin
		case (memwb_wb_sel)
			WB_ALU:  wb_data = memwb_alu_result;
			WB_MEM:  wb_data = memwb_mem_data;
			WB_PC4:  wb_data = memwb_pc + 32'd4;
			default: wb_data = memwb_imm;
		endcase
	end

endmodule

// File: rtl/core/rv_decode.sv
module rv_decode (
	input  rv_pkg::rv_instr_t i_instr,
	output logic [31:0]       o_imm,
	output logic              o_alu_src_a_pc,
	output logic              o_alu_src_b_imm,
	output logic              o_reg_write,
	output logic              o_mem_write,
	output logic              o_mem_read,
	output logic              o_branch,
	output logic              o_bne,
	output logic              o_jump,
	output logic [2:0]        o_alu_op,
	output logic [1:0]        o_wb_sel
);
	import rv_pkg::*;

	// Immediate rebuilt from the format the opcode implies
	always_comb begin
		case (i_instr.r_fmt.opcode)
			OPC_OP_IMM, OPC_LOAD:
				o_imm = {{20{i_instr.i_fmt.imm[11]}}, i_instr.i_fmt.imm};
			OPC_STORE:
				o_imm = {{20{i_instr.s_fmt.imm_hi[6]}}, i_instr.s_fmt.imm_hi,
					i_instr.s_fmt.imm_lo};
			OPC_BRANCH:
				o_imm = {{19{i_instr.b_fmt.imm_12}}, i_instr.b_fmt.imm_12,
					i_instr.b_fmt.imm_11, i_instr.b_fmt.imm_10_5,
					i_instr.b_fmt.imm_4_1, 1'b0};
			OPC_LUI:
				o_imm = {i_instr.u_fmt.imm, 12'h000};
			OPC_JAL:
				o_imm = {{11{i_instr.j_fmt.imm_20}}, i_instr.j_fmt.imm_20,
					i_instr.j_fmt.imm_19_12, i_instr.j_fmt.imm_11,
					i_instr.j_fmt.imm_10_1, 1'b0};
			default:
				o_imm = '0;
		endcase
	end

	// Control word, defaults describe a NOP
	always_comb begin
		o_alu_src_a_pc  = 1'b0;
		o_alu_src_b_imm = 1'b0;
		o_reg_write     = 1'b0;
		o_mem_write     = 1'b0;
		o_mem_read      = 1'b0;
		o_branch        = 1'b0;
		o_bne           = 1'b0;
		o_jump          = 1'b0;
		o_alu_op        = ALU_ADD;
		o_wb_sel        = WB_ALU;
		case (i_instr.r_fmt.opcode)
			OPC_OP: begin
				o_reg_write = 1'b1;
				case (i_instr.r_fmt.funct3)
					3'b000: o_alu_op = i_instr.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
					3'b010: o_alu_op = ALU_SLT;
					3'b100: o_alu_op = ALU_XOR;
					3'b110: o_alu_op = ALU_OR;
					3'b111: o_alu_op = ALU_AND;
					// Shifts and SLTU not supported
					default: o_reg_write = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				o_alu_src_b_imm = 1'b1;
				o_reg_write     = 1'b1;
				case (i_instr.i_fmt.funct3)
					3'b000: o_alu_op = ALU_ADD;
					3'b100: o_alu_op = ALU_XOR;
					3'b110: o_alu_op = ALU_OR;
					3'b111: o_alu_op = ALU_AND;
					default: o_reg_write = 1'b0;
				endcase
			end
			OPC_LUI: begin
				// Immediate goes straight to WB
				o_reg_write = 1'b1;
				o_wb_sel    = WB_IMM;
			end
			OPC_LOAD: begin
				// Word loads only
				o_alu_src_b_imm = 1'b1;
				o_mem_read      = 1'b1;
				o_reg_write     = 1'b1;
				o_wb_sel        = WB_MEM;
			end
			OPC_STORE: begin
				o_alu_src_b_imm = 1'b1;
				o_mem_write     = 1'b1;
			end
			OPC_BRANCH: begin
				// Compare by subtraction, zero flag decides
				o_alu_op = ALU_SUB;
				o_branch = (i_instr.b_fmt.funct3 == 3'b000) ||
					(i_instr.b_fmt.funct3 == 3'b001);
				o_bne    = (i_instr.b_fmt.funct3 == 3'b001);
			end
			OPC_JAL: begin
				// ALU sees PC plus offset as well
				o_alu_src_a_pc  = 1'b1;
				o_alu_src_b_imm = 1'b1;
				o_jump          = 1'b1;
				o_reg_write     = 1'b1;
				o_wb_sel        = WB_PC4;
			end
			default: begin
				// Unknown opcode stays a NOP
				o_alu_op = ALU_ADD;
			end
		endcase
	end

endmodule

// File: rtl/core/rv_regfile.sv
module rv_regfile (
	input  logic        i_clk,
	input  logic        i_we,
	input  logic [4:0]  i_waddr,
	input  logic [31:0] i_wdata,
	input  logic [4:0]  i_raddr1,
	input  logic [4:0]  i_raddr2,
	output logic [31:0] o_rdata1,
	output logic [31:0] o_rdata2
);

	// x1 to x31, x0 has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge i_clk) begin
		if (i_we && (i_waddr != 5'd0)) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// Write-through so WB and ID can share a cycle
	assign o_rdata1 = (i_raddr1 == 5'd0) ? 32'h0 :
		(i_we && (i_waddr == i_raddr1)) ? i_wdata : regs[i_raddr1];

	assign o_rdata2 = (i_raddr2 == 5'd0) ? 32'h0 :
		(i_we && (i_waddr == i_raddr2)) ? i_wdata : regs[i_raddr2];

endmodule

// File: rtl/risc_v_top.sv
module risc_v_top (
	input  logic        i_clk_50mhz,
	input  logic        i_rst_n,
	output logic [31:0] o_imem_addr,
	input  logic [31:0] i_imem_data,
	output logic        o_tx
);

	// Core to memory map
	logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
	logic        dmem_we, dmem_re;
	// Memory map to UART
	logic        uart_we;
	logic [31:0] uart_wdata;

	// No PLL, board clock drives everything
	rv_core core_i (
		.i_clk(i_clk_50mhz),
		.i_rst_n(i_rst_n),
		.o_imem_addr(o_imem_addr),
		.i_imem_data(i_imem_data),
		.o_dmem_addr(dmem_addr),
		.o_dmem_wdata(dmem_wdata),
		.o_dmem_we(dmem_we),
		.o_dmem_re(dmem_re),
		.i_dmem_rdata(dmem_rdata)
	);

	rv_mem_map mem_map_i (
		.i_clk(i_clk_50mhz),
		.i_addr(dmem_addr),
		.i_wdata(dmem_wdata),
		.i_we(dmem_we),
		.i_re(dmem_re),
		.o_rdata(dmem_rdata),
		.o_uart_we(uart_we),
		.o_uart_wdata(uart_wdata)
	);

	uart_tx uart_tx_i (
		.i_clk(i_clk_50mhz),
		.i_rst_n(i_rst_n),
		.i_we(uart_we),
		.i_wdata(uart_wdata),
		.o_tx(o_tx)
	);

endmodule

// File: rtl/rv_mem_map.sv
module rv_mem_map (
	input  logic        i_clk,
	input  logic [31:0] i_addr,
	input  logic [31:0] i_wdata,
	input  logic        i_we,
	input  logic        i_re,
	output logic [31:0] o_rdata,
	output logic        o_uart_we,
	output logic [31:0] o_uart_wdata
);
	import rv_pkg::*;

	// Data RAM, word addressed
	logic [31:0]           ram [2**RAM_ADDR_W];
	logic [RAM_ADDR_W-1:0] ram_idx;
	logic                  uart_sel;
	logic                  ram_we;

	// Bit 31 splits RAM from the UART region
	assign uart_sel = (i_addr[31] == UART_TX_ADDR[31]);
	assign ram_idx  = i_addr[RAM_ADDR_W+1:2];
	assign ram_we   = i_we & ~uart_sel;

	always_ff @(posedge i_clk) begin
		if (ram_we) begin
			ram[ram_idx] <= i_wdata;
		end
	end

	// Asynchronous read, UART reads back zero
	assign o_rdata = (i_re && !uart_sel) ? ram[ram_idx] : 32'h0;

	// Single-cycle push strobe toward the TX FIFO
	assign o_uart_we    = i_we & uart_sel;
	assign o_uart_wdata = i_wdata;

endmodule

// File: rtl/uart/uart_tx.sv
module uart_tx (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_we,
	input  logic [31:0] i_wdata,
	output logic        o_tx
);
	import rv_pkg::*;

	// Word FIFO
	logic [31:0]         fifo_mem [TX_FIFO_DEPTH];
	logic [TX_PTR_W-1:0] wr_ptr, rd_ptr;
	logic [TX_PTR_W:0]   fifo_count;
	logic                fifo_empty;
	logic                push, pop, bypass, start;
	logic [31:0]         start_word;

	// Serializer state
	logic                  busy;
	logic [9:0]            frame;
	logic [31:0]           tx_word;
	logic [1:0]            byte_cnt;
	logic [3:0]            bit_cnt;
	logic [BAUD_CNT_W-1:0] baud_cnt;

	assign fifo_empty = (fifo_count == '0);
	// Idle and empty, so the word skips the FIFO
	assign bypass     = i_we & ~busy & fifo_empty;
	assign push       = i_we & ~bypass;
	assign pop        = ~busy & ~fifo_empty;
	assign start      = pop | bypass;
	assign start_word = fifo_empty ? i_wdata : fifo_mem[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= i_wdata;
		end
	end

	// Pointers wrap on the power-of-two depth
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   fifo_count <= fifo_count + 1'b1;
				2'b01:   fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count;
			endcase
		end
	end

	// Frame is stop, data LSB first, start, sent from bit 0
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy     <= 1'b0;
			frame    <= '1;
			tx_word  <= '0;
			byte_cnt <= '0;
			bit_cnt  <= '0;
			baud_cnt <= '0;
		end else if (start) begin
			busy     <= 1'b1;
			frame    <= {1'b1, start_word[7:0], 1'b0};
			tx_word  <= {8'h00, start_word[31:8]};
			byte_cnt <= '0;
			bit_cnt  <= '0;
			baud_cnt <= '0;
		end else if (busy) begin
			if (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
				baud_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					bit_cnt <= '0;
					if (byte_cnt == 2'd3) begin
						// Last stop bit done, line back to idle
						busy  <= 1'b0;
						frame <= '1;
					end else begin
						// Next byte follows without a gap
						byte_cnt <= byte_cnt + 1'b1;
						frame    <= {1'b1, tx_word[7:0], 1'b0};
						tx_word  <= {8'h00, tx_word[31:8]};
					end
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					frame   <= {1'b1, frame[9:1]};
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// Registered line, high when idle
	assign o_tx = frame[0];

endmodule

// File: sim/risc_v_top_asserts.sv
module risc_v_top_asserts (
	input logic                    i_clk,
	input logic                    i_rst_n,
	input logic [31:0]             i_imem_addr,
	input logic                    i_uart_we,
	input logic [rv_pkg::TX_PTR_W:0] i_fifo_count,
	input logic                    i_dmem_we,
	input logic                    i_dmem_re
);
	import rv_pkg::*;

	// Polled by the testbench top
	int unsigned error_count;

	initial error_count = 0;

	// Software keeps to the FIFO depth, no back-pressure exists
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_uart_we |-> (i_fifo_count < TX_FIFO_DEPTH))
	else begin
		error_count++;
		$error("UART push while the TX FIFO is full");
	end

	// PC only ever moves in whole words
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_imem_addr[1:0] == 2'b00)
	else begin
		error_count++;
		$error("Fetch address not word aligned");
	end

	// One memory instruction per cycle
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_dmem_we && i_dmem_re))
	else begin
		error_count++;
		$error("Data RAM written and read in the same cycle");
	end

endmodule

// File: sim/tb_risc_v_top.sv
module tb_risc_v_top;
	import rv_pkg::*;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic        tx;

	// Instruction ROM served to the fetch port
	logic [31:0] rom [256];
	int          prog_len;
	logic [31:0] final_pc;
	logic [4:0]  last_rd [2];

	// Model predictions
	logic [31:0] exp_words [$];
	logic [31:0] fetch_q [$];
	int          words_total;
	int          words_seen;
	logic        fetch_on;

	int    seed;
	string cur_test;
	int    watch_cycles;
	int    watch_limit;

	risc_v_top dut_i (
		.i_clk_50mhz(clk),
		.i_rst_n(rst_n),
		.o_imem_addr(imem_addr),
		.i_imem_data(imem_data),
		.o_tx(tx)
	);

	bind risc_v_top risc_v_top_asserts asserts_i (
		.i_clk(i_clk_50mhz),
		.i_rst_n(i_rst_n),
		.i_imem_addr(o_imem_addr),
		.i_uart_we(uart_we),
		.i_fifo_count(uart_tx_i.fifo_count),
		.i_dmem_we(dmem_we),
		.i_dmem_re(dmem_re)
	);

	always #5 clk = ~clk;

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR %s UART word: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	task automatic check_addr(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR %s fetch address: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Encoders for each instruction format
	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		rv_instr_t w;
		w.r_fmt.funct7 = f7;
		w.r_fmt.rs2    = rs2;
		w.r_fmt.rs1    = rs1;
		w.r_fmt.funct3 = f3;
		w.r_fmt.rd     = rd;
		w.r_fmt.opcode = OPC_OP;
		return w;
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		rv_instr_t w;
		w.i_fmt.imm    = imm;
		w.i_fmt.rs1    = rs1;
		w.i_fmt.funct3 = f3;
		w.i_fmt.rd     = rd;
		w.i_fmt.opcode = opc;
		return w;
	endfunction

	// SW rs2, imm(rs1)
	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [4:0] rs2);
		rv_instr_t w;
		w.s_fmt.imm_hi = imm[11:5];
		w.s_fmt.rs2    = rs2;
		w.s_fmt.rs1    = rs1;
		w.s_fmt.funct3 = 3'b010;
		w.s_fmt.imm_lo = imm[4:0];
		w.s_fmt.opcode = OPC_STORE;
		return w;
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [2:0] f3);
		rv_instr_t w;
		w.b_fmt.imm_12   = off[12];
		w.b_fmt.imm_10_5 = off[10:5];
		w.b_fmt.rs2      = rs2;
		w.b_fmt.rs1      = rs1;
		w.b_fmt.funct3   = f3;
		w.b_fmt.imm_4_1  = off[4:1];
		w.b_fmt.imm_11   = off[11];
		w.b_fmt.opcode   = OPC_BRANCH;
		return w;
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
		rv_instr_t w;
		w.u_fmt.imm    = imm;
		w.u_fmt.rd     = rd;
		w.u_fmt.opcode = OPC_LUI;
		return w;
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
		rv_instr_t w;
		w.j_fmt.imm_20    = off[20];
		w.j_fmt.imm_10_1  = off[10:1];
		w.j_fmt.imm_11    = off[11];
		w.j_fmt.imm_19_12 = off[19:12];
		w.j_fmt.rd        = rd;
		w.j_fmt.opcode    = OPC_JAL;
		return w;
	endfunction

	// Both source fields count even where they hold immediate bits
	function automatic logic reads_reg(input rv_instr_t w, input logic [4:0] r);
		return (r != 5'd0) && ((w.r_fmt.rs1 == r) || (w.r_fmt.rs2 == r));
	endfunction

	function automatic logic [4:0] dest_reg(input rv_instr_t w);
		case (w.r_fmt.opcode)
			OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_LOAD, OPC_JAL: return w.r_fmt.rd;
			default: return 5'd0;
		endcase
	endfunction

	// Append one instruction with NOPs first while a recent result is in flight
	task automatic place_instr(input logic [31:0] w);
		while (reads_reg(w, last_rd[0]) || reads_reg(w, last_rd[1])) begin
			rom[prog_len] = NOP_INSTR;
			prog_len++;
			last_rd[1] = last_rd[0];
			last_rd[0] = 5'd0;
		end
		rom[prog_len] = w;
		prog_len++;
		last_rd[1] = last_rd[0];
		last_rd[0] = dest_reg(w);
	endtask

	task automatic generate_program();
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [12:0] off;
		int          n_words;
		for (int i = 0; i < 256; i++) begin
			rom[i] = NOP_INSTR;
		end
		prog_len   = 0;
		last_rd[0] = 5'd0;
		last_rd[1] = 5'd0;
		// Prologue gives the used registers and RAM words known values
		for (int r = 1; r < 16; r++) begin
			place_instr(i_word(12'(pick(4096)), 5'd0, 3'b000, 5'(r), OPC_OP_IMM));
		end
		for (int a = 0; a < 8; a++) begin
			place_instr(s_word(12'(a * 4), 5'd0, 5'd0));
		end
		for (int n = 0; n < 40; n++) begin
			rd  = 5'(1 + pick(15));
			rs1 = 5'(1 + pick(15));
			rs2 = 5'(1 + pick(15));
			// Forward only by up to four slots
			off = 13'((1 + pick(4)) * 4);
			case (pick(10))
				0, 1, 2: begin
					case (pick(6))
						0: place_instr(r_word(7'h00, rs2, rs1, 3'b000, rd));
						1: place_instr(r_word(7'h20, rs2, rs1, 3'b000, rd));
						2: place_instr(r_word(7'h00, rs2, rs1, 3'b010, rd));
						3: place_instr(r_word(7'h00, rs2, rs1, 3'b100, rd));
						4: place_instr(r_word(7'h00, rs2, rs1, 3'b110, rd));
						default: place_instr(r_word(7'h00, rs2, rs1, 3'b111, rd));
					endcase
				end
				3, 4: begin
					case (pick(4))
						0: place_instr(i_word(12'(pick(4096)), rs1, 3'b000, rd, OPC_OP_IMM));
						1: place_instr(i_word(12'(pick(4096)), rs1, 3'b100, rd, OPC_OP_IMM));
						2: place_instr(i_word(12'(pick(4096)), rs1, 3'b110, rd, OPC_OP_IMM));
						default: place_instr(i_word(12'(pick(4096)), rs1, 3'b111, rd,
							OPC_OP_IMM));
					endcase
				end
				5: place_instr(u_word(20'(pick(1 << 20)), rd));
				6: place_instr(s_word(12'(pick(8) * 4), 5'd0, rs2));
				7: place_instr(i_word(12'(pick(8) * 4), 5'd0, 3'b010, rd, OPC_LOAD));
				8: begin
					// Equal operands half the time so BEQ gets taken too
					if (pick(2) == 1) begin
						rs2 = rs1;
					end
					place_instr(b_word(off, rs1, rs2, (pick(2) == 1) ? 3'b001 : 3'b000));
				end
				default: place_instr(j_word(21'(off), rd));
			endcase
		end
		// Landing room for the last branch targets
		repeat (4) place_instr(NOP_INSTR);
		place_instr(u_word(20'h80000, 5'd31));
		n_words = 4 + pick(5);
		repeat (n_words) place_instr(s_word(12'd0, 5'd31, 5'(1 + pick(15))));
		place_instr(j_word(21'd0, 5'd0));
		final_pc = 32'((prog_len - 1) * 4);
	endtask

	// ISA level model that also records the expected fetch stream
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] mem [128];
		logic [31:0] pc, imm, a, b, res, target, addr;
		rv_instr_t   ins;
		logic        taken, wr;
		int          steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = 32'h0;
		end
		for (int i = 0; i < 128; i++) begin
			mem[i] = 32'h0;
		end
		exp_words.delete();
		fetch_q.delete();
		pc    = 32'h0;
		steps = 0;
		while ((pc != final_pc) && (steps < 2000)) begin
			ins    = rom[pc[9:2]];
			a      = regs[ins.r_fmt.rs1];
			b      = regs[ins.r_fmt.rs2];
			wr     = 1'b0;
			taken  = 1'b0;
			res    = 32'h0;
			target = pc + 32'd4;
			fetch_q.push_back(pc);
			case (ins.r_fmt.opcode)
				OPC_OP: begin
					wr = 1'b1;
					case (ins.r_fmt.funct3)
						3'b000: res = ins.r_fmt.funct7[5] ? a - b : a + b;
						3'b010: res = {31'd0, $signed(a) < $signed(b)};
						3'b100: res = a ^ b;
						3'b110: res = a | b;
						default: res = a & b;
					endcase
				end
				OPC_OP_IMM: begin
					wr  = 1'b1;
					imm = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
					case (ins.i_fmt.funct3)
						3'b000: res = a + imm;
						3'b100: res = a ^ imm;
						3'b110: res = a | imm;
						default: res = a & imm;
					endcase
				end
				OPC_LUI: begin
					wr  = 1'b1;
					res = {ins.u_fmt.imm, 12'h000};
				end
				OPC_LOAD: begin
					wr   = 1'b1;
					addr = a + {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
					res  = mem[addr[8:2]];
				end
				OPC_STORE: begin
					addr = a + {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
					// Bit 31 selects the UART
					if (addr[31]) begin
						exp_words.push_back(b);
					end else begin
						mem[addr[8:2]] = b;
					end
				end
				OPC_BRANCH: begin
					imm    = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
						ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
					taken  = (ins.b_fmt.funct3 == 3'b001) ? (a != b) : (a == b);
					target = taken ? pc + imm : target;
				end
				OPC_JAL: begin
					imm    = {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
						ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
					wr     = 1'b1;
					res    = pc + 32'd4;
					taken  = 1'b1;
					target = pc + imm;
				end
				default: wr = 1'b0;
			endcase
			if (wr && (ins.r_fmt.rd != 5'd0)) begin
				regs[ins.r_fmt.rd] = res;
			end
			// Three fetches go by before a redirect lands
			if (taken) begin
				fetch_q.push_back(pc + 32'd4);
				fetch_q.push_back(pc + 32'd8);
				fetch_q.push_back(pc + 32'd12);
			end
			pc = target;
			steps++;
		end
		if (steps >= 2000) begin
			fail_run("Model never reached the final JAL of the program");
		end
		// Final self jump and its shadow
		for (int i = 0; i < 4; i++) begin
			fetch_q.push_back(final_pc + 32'(i * 4));
		end
	endtask

	task automatic run_program(input int idx);
		cur_test = $sformatf("program %0d", idx);
		fetch_on = 1'b0;
		rst_n    = 1'b0;
		generate_program();
		run_model();
		words_total  = exp_words.size();
		words_seen   = 0;
		watch_cycles = 0;
		watch_limit  = 8 + fetch_q.size() + words_total * 4 * 10 * CLKS_PER_BIT + 200;
		repeat (4) @(posedge clk);
		#1;
		rst_n    = 1'b1;
		fetch_on = 1'b1;
		if (tx !== 1'b1) begin
			fail_run($sformatf("%s: UART line not idle high after reset", cur_test));
		end
		wait (words_seen == words_total);
		@(posedge clk);
		#1;
	endtask

	// Fetch port served a small delay after the edge
	always @(posedge clk) begin
		#1;
		imem_data = rom[imem_addr[9:2]];
	end

	// PC is stable at the falling edge
	always @(negedge clk) begin
		if (fetch_on && (fetch_q.size() != 0)) begin
			check_addr(cur_test, fetch_q.pop_front(), imem_addr);
		end
	end

	// 8N1 receiver sampling mid bit, LSB first with four bytes per word
	initial begin : uart_monitor
		logic [7:0]  rx_byte;
		logic [31:0] rx_word;
		int          n_bytes;
		n_bytes = 0;
		rx_word = 32'h0;
		rx_byte = 8'h0;
		forever begin
			@(negedge tx);
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			if (tx !== 1'b0) begin
				fail_run($sformatf("%s: UART start bit did not stay low", cur_test));
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				rx_byte[i] = tx;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			if (tx !== 1'b1) begin
				fail_run($sformatf("%s: UART stop bit was not high", cur_test));
			end
			rx_word = {rx_byte, rx_word[31:8]};
			n_bytes++;
			if (n_bytes == 4) begin
				n_bytes = 0;
				if (exp_words.size() == 0) begin
					fail_run($sformatf("%s: UART sent a word the model did not expect",
						cur_test));
				end
				check_word(cur_test, exp_words.pop_front(), rx_word);
				words_seen++;
			end
		end
	end

	always @(negedge clk) begin
		if (dut_i.asserts_i.error_count != 0) begin
			fail_run("A bound assertion on the DUT fired");
		end
	end

	// Watchdog with a limit set per program
	always @(posedge clk) begin
		watch_cycles = watch_cycles + 1;
		if (watch_cycles > watch_limit) begin
			fail_run($sformatf("Timeout: %s did not finish within %0d cycles",
				cur_test, watch_limit));
		end
	end

	initial begin : main
		rst_n        = 1'b1;
		imem_data    = NOP_INSTR;
		seed         = 32'h39a764a0;
		fetch_on     = 1'b0;
		words_total  = 0;
		words_seen   = 0;
		watch_cycles = 0;
		watch_limit  = 100;
		cur_test     = "startup";
		#1;
		for (int p = 0; p < 3; p++) begin
			run_program(p);
		end
		@(posedge clk);
		if (dut_i.asserts_i.error_count != 0) begin
			fail_run("A bound assertion on the DUT fired");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

// File: verilog.f
common/rv_pkg.sv
rtl/core/rv_decode.sv
rtl/core/rv_regfile.sv
rtl/core/rv_alu.sv
rtl/core/rv_core.sv
rtl/rv_mem_map.sv
rtl/uart/uart_tx.sv
rtl/risc_v_top.sv
sim/risc_v_top_asserts.sv
sim/tb_risc_v_top.sv
